// ==== rtl/apb_regs.sv ====
`default_nettype none

module apb_regs (
    input  wire                              clk_pixel,
    input  wire                              recent_reset,
    input  wire                              psel_i,
    input  wire                              penable_i,
    input  wire                              pwrite_i,
    input  wire  [regmap_pkg::ADDR_W-1:0]    paddr_i,
    input  wire  [regmap_pkg::DATA_W-1:0]    pwdata_i,
    input  wire  [video_pkg::COORD_W-1:0]    cx_i,
    input  wire  [video_pkg::COORD_W-1:0]    cy_i,
    input  wire                              have_centroid_i,
    input  wire  [regmap_pkg::DATA_W-1:0]    pix_count_i,
    input  wire  [regmap_pkg::FRAME_W-1:0]   frame_count_i,
    output logic [regmap_pkg::DATA_W-1:0]    prdata_o,
    output logic                             pready_o,
    output logic                             pslverr_o,
    output logic [video_pkg::CHAN_W-1:0]     thresh_lo_o,
    output logic [video_pkg::CHAN_W-1:0]     thresh_hi_o,
    output video_pkg::display_mode_e         mode_o
);

    logic mapped;
    logic writable;
    logic access;
    logic bad_access;

    assign access     = psel_i && penable_i;
    assign bad_access = !mapped || (pwrite_i && !writable);
    assign pready_o   = 1'b1;  // Never any wait states
    assign pslverr_o  = access && bad_access;

    // Address decode and read mux
    always_comb begin
        prdata_o = '0;
        mapped   = 1'b1;
        writable = 1'b0;
        case (paddr_i)
            regmap_pkg::REG_THRESH_LO: begin
                prdata_o[video_pkg::CHAN_W-1:0] = thresh_lo_o;
                writable = 1'b1;
            end
            regmap_pkg::REG_THRESH_HI: begin
                prdata_o[video_pkg::CHAN_W-1:0] = thresh_hi_o;
                writable = 1'b1;
            end
            regmap_pkg::REG_MODE: begin
                prdata_o[1:0] = mode_o;
                writable = 1'b1;
            end
            regmap_pkg::REG_CENTROID: begin
                prdata_o[video_pkg::COORD_W-1:0] = cx_i;
                prdata_o[regmap_pkg::CENT_Y_LSB +: video_pkg::COORD_W] = cy_i;
                prdata_o[regmap_pkg::CENT_VALID_BIT] = have_centroid_i;
            end
            regmap_pkg::REG_COUNT: prdata_o = pix_count_i;
            regmap_pkg::REG_FRAME: prdata_o[regmap_pkg::FRAME_W-1:0] = frame_count_i;
            default: mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            thresh_lo_o <= regmap_pkg::THRESH_LO_RST;
            thresh_hi_o <= regmap_pkg::THRESH_HI_RST;
            mode_o      <= video_pkg::MODE_CAMERA;
        end else if (access && pwrite_i && !bad_access) begin
            case (paddr_i)
                regmap_pkg::REG_THRESH_LO: thresh_lo_o <= pwdata_i[video_pkg::CHAN_W-1:0];
                regmap_pkg::REG_THRESH_HI: thresh_hi_o <= pwdata_i[video_pkg::CHAN_W-1:0];
                regmap_pkg::REG_MODE:      mode_o <= video_pkg::display_mode_e'(pwdata_i[1:0]);
                default: ;
            endcase
        end
    end

    // Master must hold psel through the access phase
    a_penable_with_psel: assert property (
        @(posedge clk_pixel) disable iff (recent_reset) penable_i |-> psel_i);

endmodule

`default_nettype wire

// ==== rtl/centroid_tracker.sv ====
`default_nettype none

module centroid_tracker #(
    parameter int H_RES = 1280,
    parameter int V_RES = 720
) (
    input  wire                             clk_pixel,
    input  wire                             recent_reset,
    input  wire                             valid_i,
    input  wire  [video_pkg::COORD_W-1:0]   hcount_i,
    input  wire  [video_pkg::COORD_W-1:0]   vcount_i,
    input  wire                             mask_i,
    output logic [video_pkg::COORD_W-1:0]   cx_o,
    output logic [video_pkg::COORD_W-1:0]   cy_o,
    output logic                            have_centroid_o,
    output logic [regmap_pkg::DATA_W-1:0]   pix_count_o,
    output logic [regmap_pkg::FRAME_W-1:0]  frame_count_o
);

    localparam int CNT_W = $clog2(H_RES * V_RES + 1);
    localparam int SUM_W = video_pkg::COORD_W + CNT_W;  // Every coordinate is below 2^COORD_W

    logic [SUM_W-1:0] sum_x_q, sum_y_q, sum_x_next, sum_y_next;
    logic [CNT_W-1:0] cnt_q, cnt_next, cnt_snap_q;
    logic [SUM_W-1:0] divisor, quot_x, quot_y;
    logic             hit, last_pix, start;
    logic             busy_x, busy_y, done_x, done_y;

    assign hit      = valid_i && mask_i;
    assign last_pix = valid_i && (hcount_i == video_pkg::COORD_W'(H_RES - 1))
                              && (vcount_i == video_pkg::COORD_W'(V_RES - 1));

    // Running sums including the pixel now in the stage
    assign sum_x_next = sum_x_q + (hit ? SUM_W'(hcount_i) : '0);
    assign sum_y_next = sum_y_q + (hit ? SUM_W'(vcount_i) : '0);
    assign cnt_next   = cnt_q + CNT_W'(hit);
    assign divisor    = SUM_W'(cnt_next);
    assign start      = last_pix && (cnt_next != '0);  // Dividers latch the frame totals

    always_ff @(posedge clk_pixel) begin
        if (recent_reset || last_pix) begin  // Clear for the next frame
            sum_x_q <= '0;
            sum_y_q <= '0;
            cnt_q   <= '0;
        end else begin
            sum_x_q <= sum_x_next;
            sum_y_q <= sum_y_next;
            cnt_q   <= cnt_next;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (start) cnt_snap_q <= cnt_next;
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            cx_o            <= '0;
            cy_o            <= '0;
            have_centroid_o <= 1'b0;
            pix_count_o     <= '0;
            frame_count_o   <= '0;
        end else if (last_pix && cnt_next == '0) begin
            pix_count_o   <= '0;  // Empty frame keeps the old centroid
            frame_count_o <= frame_count_o + 1'b1;
        end else if (done_x && done_y) begin
            cx_o            <= quot_x[video_pkg::COORD_W-1:0];
            cy_o            <= quot_y[video_pkg::COORD_W-1:0];
            have_centroid_o <= 1'b1;
            pix_count_o     <= regmap_pkg::DATA_W'(cnt_snap_q);
            frame_count_o   <= frame_count_o + 1'b1;
        end
    end

    serial_divider #(.WIDTH(SUM_W)) div_x_i (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .start_i     (start),
        .dividend_i  (sum_x_next),
        .divisor_i   (divisor),
        .quotient_o  (quot_x),
        .busy_o      (busy_x),
        .done_o      (done_x)
    );

    serial_divider #(.WIDTH(SUM_W)) div_y_i (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .start_i     (start),
        .dividend_i  (sum_y_next),
        .divisor_i   (divisor),
        .quotient_o  (quot_y),
        .busy_o      (busy_y),
        .done_o      (done_y)
    );

    // A frame never ends while the dividers still work on the previous one
    a_frame_end_when_idle: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        last_pix |-> (!busy_x && !busy_y));

endmodule

`default_nettype wire

// ==== rtl/overlay_mux.sv ====
`default_nettype none

module overlay_mux (
    input  wire                             clk_pixel,
    input  wire                             recent_reset,
    input  wire                             valid_i,
    input  wire  [video_pkg::COORD_W-1:0]   hcount_i,
    input  wire  [video_pkg::COORD_W-1:0]   vcount_i,
    input  wire  [video_pkg::RGB888_W-1:0]  rgb_i,
    input  wire  [video_pkg::CHAN_W-1:0]    luma_i,
    input  wire                             mask_i,
    input  wire  video_pkg::display_mode_e  mode_i,
    input  wire  [video_pkg::COORD_W-1:0]   cx_i,
    input  wire  [video_pkg::COORD_W-1:0]   cy_i,
    input  wire                             have_centroid_i,
    output logic                            out_valid_o,
    output logic [video_pkg::COORD_W-1:0]   out_hcount_o,
    output logic [video_pkg::COORD_W-1:0]   out_vcount_o,
    output logic [video_pkg::RGB888_W-1:0]  out_rgb_o
);

    logic                           on_cross;
    logic [video_pkg::RGB888_W-1:0] pixel;

    assign on_cross = have_centroid_i && (hcount_i == cx_i || vcount_i == cy_i);

    always_comb begin
        case (mode_i)
            video_pkg::MODE_LUMA:  pixel = {3{luma_i}};  // Grey scale
            video_pkg::MODE_MASK:  pixel = mask_i ? 24'hFFFFFF : 24'h000000;
            video_pkg::MODE_TRACK: pixel = on_cross ? video_pkg::CROSS_COLOR : rgb_i;
            default:               pixel = rgb_i;
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset)
            out_valid_o <= 1'b0;
        else
            out_valid_o <= valid_i;
    end

    always_ff @(posedge clk_pixel) begin
        out_hcount_o <= hcount_i;
        out_vcount_o <= vcount_i;
        out_rgb_o    <= pixel;
    end

endmodule

`default_nettype wire

// ==== rtl/pixel_mask.sv ====
`default_nettype none

module pixel_mask #(
    parameter int H_RES = 1280,
    parameter int V_RES = 720
) (
    input  wire                             clk_pixel,
    input  wire                             recent_reset,
    input  wire                             pix_valid_i,
    input  wire  [video_pkg::RGB565_W-1:0]  pix_data_i,
    input  wire  [video_pkg::COORD_W-1:0]   hcount_i,
    input  wire  [video_pkg::COORD_W-1:0]   vcount_i,
    input  wire  [video_pkg::CHAN_W-1:0]    thresh_lo_i,
    input  wire  [video_pkg::CHAN_W-1:0]    thresh_hi_i,
    output logic                            valid_o,
    output logic [video_pkg::COORD_W-1:0]   hcount_o,
    output logic [video_pkg::COORD_W-1:0]   vcount_o,
    output logic [video_pkg::RGB888_W-1:0]  rgb_o,
    output logic [video_pkg::CHAN_W-1:0]    luma_o,
    output logic                            mask_o
);

    logic [video_pkg::CHAN_W-1:0] r8, g8, b8;
    logic [10:0]                  luma_sum;  // 2r + 5g + b, at most 2040
    logic [video_pkg::CHAN_W-1:0] luma;

    assign r8 = {pix_data_i[15:11], 3'b000};
    assign g8 = {pix_data_i[10:5], 2'b00};
    assign b8 = {pix_data_i[4:0], 3'b000};

    assign luma_sum = 11'({r8, 1'b0}) + 11'(g8) * 11'd5 + 11'(b8);
    assign luma     = luma_sum[10:3];  // Divide by 8

    always_ff @(posedge clk_pixel) begin
        if (recent_reset)
            valid_o <= 1'b0;
        else
            valid_o <= pix_valid_i;
    end

    always_ff @(posedge clk_pixel) begin
        hcount_o <= hcount_i;
        vcount_o <= vcount_i;
        rgb_o    <= {r8, g8, b8};
        luma_o   <= luma;
        mask_o   <= (luma > thresh_lo_i) && (luma <= thresh_hi_i);  // Window is (lo, hi]
    end

    a_coords_in_frame: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        pix_valid_i |-> (hcount_i < H_RES) && (vcount_i < V_RES));

endmodule

`default_nettype wire

// ==== rtl/regmap_pkg.sv ====
`default_nettype none

package regmap_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // Register word addresses
    typedef enum logic [ADDR_W-1:0] {
        REG_THRESH_LO = 8'h00,  // RW, luma must be above this
        REG_THRESH_HI = 8'h04,  // RW, luma must be at or below this
        REG_MODE      = 8'h08,  // RW, display mode
        REG_CENTROID  = 8'h0C,  // RO
        REG_COUNT     = 8'h10,  // RO, masked pixels of last frame
        REG_FRAME     = 8'h14   // RO, frames completed
    } reg_addr_e;

    localparam logic [7:0] THRESH_LO_RST = 8'h80;
    localparam logic [7:0] THRESH_HI_RST = 8'hFF;

    // REG_CENTROID fields, x sits at bit 0
    localparam int CENT_Y_LSB     = 16;
    localparam int CENT_VALID_BIT = 31;

    localparam int FRAME_W = 16;

endpackage

`default_nettype wire

// ==== rtl/serial_divider.sv ====
`default_nettype none

module serial_divider #(
    parameter int WIDTH = 32
) (
    input  wire              clk_pixel,
    input  wire              recent_reset,
    input  wire              start_i,
    input  wire  [WIDTH-1:0] dividend_i,
    input  wire  [WIDTH-1:0] divisor_i,
    output logic [WIDTH-1:0] quotient_o,
    output logic             busy_o,
    output logic             done_o
);

    typedef enum logic [1:0] {IDLE, SHIFT, DONE} state_e;

    state_e                     state_q;
    logic [$clog2(WIDTH+1)-1:0] step_q;     // Steps left in SHIFT
    logic [WIDTH-1:0]           rem_q;
    logic [WIDTH-1:0]           divisor_q;
    logic [WIDTH:0]             rem_shift;  // Remainder with next dividend bit brought in

    // Quotient register doubles as the dividend shift register
    assign rem_shift = {rem_q, quotient_o[WIDTH-1]};
    assign busy_o    = (state_q != IDLE);
    assign done_o    = (state_q == DONE);

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            state_q <= IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                IDLE: if (start_i) begin
                    state_q <= SHIFT;
                    step_q  <= ($clog2(WIDTH+1))'(WIDTH);
                end
                SHIFT: begin
                    step_q <= step_q - 1'b1;
                    if (step_q == 1) state_q <= DONE;
                end
                DONE:    state_q <= IDLE;  // One-cycle done pulse
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (state_q == IDLE && start_i) begin
            quotient_o <= dividend_i;
            rem_q      <= '0;
            divisor_q  <= divisor_i;
        end else if (state_q == SHIFT) begin
            if (rem_shift >= {1'b0, divisor_q}) begin  // Trial subtract fits
                rem_q      <= WIDTH'(rem_shift - {1'b0, divisor_q});
                quotient_o <= {quotient_o[WIDTH-2:0], 1'b1};
            end else begin
                rem_q      <= rem_shift[WIDTH-1:0];  // Restore
                quotient_o <= {quotient_o[WIDTH-2:0], 1'b0};
            end
        end
    end

    a_no_start_when_busy: assert property (
        @(posedge clk_pixel) disable iff (recent_reset) start_i |-> !busy_o);

endmodule

`default_nettype wire

// ==== rtl/tracker_top.sv ====
`default_nettype none

module tracker_top #(
    parameter int H_RES = 1280,
    parameter int V_RES = 720
) (
    input  wire                             clk_pixel,
    input  wire                             recent_reset,
    // Pixel input
    input  wire                             pix_valid_i,
    input  wire  [video_pkg::RGB565_W-1:0]  pix_data_i,
    input  wire  [video_pkg::COORD_W-1:0]   hcount_i,
    input  wire  [video_pkg::COORD_W-1:0]   vcount_i,
    // APB slave
    input  wire                             psel_i,
    input  wire                             penable_i,
    input  wire                             pwrite_i,
    input  wire  [regmap_pkg::ADDR_W-1:0]   paddr_i,
    input  wire  [regmap_pkg::DATA_W-1:0]   pwdata_i,
    output logic [regmap_pkg::DATA_W-1:0]   prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    // Pixel output
    output logic                            out_valid_o,
    output logic [video_pkg::RGB888_W-1:0]  out_rgb_o,
    output logic [video_pkg::COORD_W-1:0]   out_hcount_o,
    output logic [video_pkg::COORD_W-1:0]   out_vcount_o
);

    logic [video_pkg::CHAN_W-1:0]    thresh_lo, thresh_hi;
    video_pkg::display_mode_e        mode;
    logic                            st_valid, st_mask;  // pixel_mask stage
    logic [video_pkg::COORD_W-1:0]   st_hcount, st_vcount;
    logic [video_pkg::RGB888_W-1:0]  st_rgb;
    logic [video_pkg::CHAN_W-1:0]    st_luma;
    logic [video_pkg::COORD_W-1:0]   cx, cy;
    logic                            have_centroid;
    logic [regmap_pkg::DATA_W-1:0]   pix_count;
    logic [regmap_pkg::FRAME_W-1:0]  frame_count;

    apb_regs regs_i (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .cx_i(cx), .cy_i(cy), .have_centroid_i(have_centroid),
        .pix_count_i(pix_count), .frame_count_i(frame_count),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .thresh_lo_o(thresh_lo), .thresh_hi_o(thresh_hi), .mode_o(mode)
    );

    pixel_mask #(.H_RES(H_RES), .V_RES(V_RES)) mask_i (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .pix_valid_i(pix_valid_i), .pix_data_i(pix_data_i),
        .hcount_i(hcount_i), .vcount_i(vcount_i),
        .thresh_lo_i(thresh_lo), .thresh_hi_i(thresh_hi),
        .valid_o(st_valid), .hcount_o(st_hcount), .vcount_o(st_vcount),
        .rgb_o(st_rgb), .luma_o(st_luma), .mask_o(st_mask)
    );

    centroid_tracker #(.H_RES(H_RES), .V_RES(V_RES)) tracker_i (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .valid_i(st_valid), .hcount_i(st_hcount), .vcount_i(st_vcount), .mask_i(st_mask),
        .cx_o(cx), .cy_o(cy), .have_centroid_o(have_centroid),
        .pix_count_o(pix_count), .frame_count_o(frame_count)
    );

    overlay_mux overlay_i (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .valid_i(st_valid), .hcount_i(st_hcount), .vcount_i(st_vcount),
        .rgb_i(st_rgb), .luma_i(st_luma), .mask_i(st_mask), .mode_i(mode),
        .cx_i(cx), .cy_i(cy), .have_centroid_i(have_centroid),
        .out_valid_o(out_valid_o), .out_hcount_o(out_hcount_o),
        .out_vcount_o(out_vcount_o), .out_rgb_o(out_rgb_o)
    );

endmodule

`default_nettype wire

// ==== rtl/video_pkg.sv ====
`default_nettype none

package video_pkg;

    localparam int RGB565_W = 16;  // Camera pixel, 5:6:5
    localparam int CHAN_W   = 8;
    localparam int RGB888_W = 24;  // Display pixel, 8:8:8
    localparam int COORD_W  = 11;  // Wide enough for hcount up to 2047

    // What the pixel output shows
    typedef enum logic [1:0] {
        MODE_CAMERA = 2'd0,
        MODE_LUMA   = 2'd1,
        MODE_MASK   = 2'd2,
        MODE_TRACK  = 2'd3   // Camera with crosshair on the centroid
    } display_mode_e;

    localparam logic [RGB888_W-1:0] CROSS_COLOR = 24'h00FF00;

endpackage

`default_nettype wire

// ==== sources.f ====
rtl/video_pkg.sv
rtl/regmap_pkg.sv
rtl/serial_divider.sv
rtl/apb_regs.sv
rtl/pixel_mask.sv
rtl/centroid_tracker.sv
rtl/overlay_mux.sv
rtl/tracker_top.sv
tests/tb_tracker.sv

// ==== tests/tb_tracker.sv ====
`default_nettype none

module tb_tracker;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_RES        = 16;
    localparam int V_RES        = 8;
    localparam int N_PIX        = H_RES * V_RES;
    localparam int CLK_PERIOD   = 4;
    localparam int N_FRAMES     = 5;
    localparam int FRAME_CYCLES = 2 * N_PIX + 200;  // Idle cycles plus result polling
    localparam int TIMEOUT_NS   = (N_FRAMES * FRAME_CYCLES + 500) * CLK_PERIOD * 3;

    logic                              clk_pixel;
    logic                              recent_reset;
    logic                              pix_valid;
    logic [video_pkg::RGB565_W-1:0]    pix_data;
    logic [video_pkg::COORD_W-1:0]     hcount, vcount;
    logic                              psel, penable, pwrite;
    logic [regmap_pkg::ADDR_W-1:0]     paddr;
    logic [regmap_pkg::DATA_W-1:0]     pwdata, prdata;
    logic                              pready, pslverr;
    logic                              out_valid;
    logic [video_pkg::RGB888_W-1:0]    out_rgb;
    logic [video_pkg::COORD_W-1:0]     out_hcount, out_vcount;

    logic [31:0]                       lcg_state = 32'h1728e7a1;
    int unsigned                       cycle_cnt = 0;
    logic [video_pkg::RGB565_W-1:0]    frame_mem [N_PIX];

    // Expected output pixels with the cycle they must appear in
    logic [video_pkg::RGB888_W-1:0]    exp_rgb_q [$];
    logic [video_pkg::COORD_W-1:0]     exp_h_q [$];
    logic [video_pkg::COORD_W-1:0]     exp_v_q [$];
    int unsigned                       exp_cyc_q [$];

    // Reference model state
    logic [7:0]                        model_lo, model_hi;
    video_pkg::display_mode_e          model_mode;
    logic [video_pkg::COORD_W-1:0]     model_cx, model_cy;
    logic                              model_have;
    int unsigned                       model_frames;
    int unsigned                       sum_x, sum_y, frame_hits;

    tracker_top #(.H_RES(H_RES), .V_RES(V_RES)) dut_i (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .pix_valid_i(pix_valid), .pix_data_i(pix_data),
        .hcount_i(hcount), .vcount_i(vcount),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
        .out_valid_o(out_valid), .out_rgb_o(out_rgb),
        .out_hcount_o(out_hcount), .out_vcount_o(out_vcount)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pixel = ~clk_pixel;
    end

    always @(posedge clk_pixel) cycle_cnt <= cycle_cnt + 1;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [23:0] expand_rgb(input logic [15:0] p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    function automatic logic [7:0] luma_of(input logic [15:0] p);
        int unsigned r, g, b;
        r = {p[15:11], 3'b000};
        g = {p[10:5], 2'b00};
        b = {p[4:0], 3'b000};
        return 8'((2 * r + 5 * g + b) / 8);
    endfunction

    function automatic logic in_window(input logic [7:0] l);
        return (l > model_lo) && (l <= model_hi);
    endfunction

    function automatic logic [23:0] expected_rgb(input logic [15:0] p,
                                                  input logic [10:0] h, input logic [10:0] v);
        case (model_mode)
            video_pkg::MODE_LUMA:  return {3{luma_of(p)}};
            video_pkg::MODE_MASK:  return in_window(luma_of(p)) ? 24'hFFFFFF : 24'h000000;
            video_pkg::MODE_TRACK:
                return (model_have && (h == model_cx || v == model_cy)) ? 24'h00FF00
                                                                        : expand_rgb(p);
            default:               return expand_rgb(p);
        endcase
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic apb_transfer(input logic [7:0] addr, input logic write,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic err);
        @(negedge clk_pixel);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk_pixel);
        penable = 1'b1;
        #1;  // Mid access phase, ahead of the completing edge
        check_equal(pready, 1'b1, "pready during access");
        rdata = prdata;
        err   = pslverr;
        @(negedge clk_pixel);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_transfer(addr, 1'b1, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(addr, 1'b0, 32'h0, data, err);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check_equal(err, 1'b0, "pslverr on a valid write");
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_equal(err, 1'b0, "pslverr on a valid read");
        check_equal(data, exp, what);
    endtask

    task automatic configure(input logic [7:0] lo, input logic [7:0] hi,
                             input video_pkg::display_mode_e mode);
        write_reg(regmap_pkg::REG_THRESH_LO, 32'(lo));
        write_reg(regmap_pkg::REG_THRESH_HI, 32'(hi));
        write_reg(regmap_pkg::REG_MODE, 32'(mode));
        model_lo   = lo;
        model_hi   = hi;
        model_mode = mode;
    endtask

    // Raster frame of random pixels with random idle gaps
    task automatic send_frame();
        logic [31:0] rnd;
        logic [10:0] h, v;
        for (int i = 0; i < N_PIX; i++) begin
            rnd          = next_random();
            frame_mem[i] = rnd[31:16];
        end
        sum_x      = 0;
        sum_y      = 0;
        frame_hits = 0;
        for (int i = 0; i < N_PIX; i++) begin
            rnd = next_random();
            if (rnd[27:24] < 4) begin
                @(negedge clk_pixel);
                pix_valid = 1'b0;
            end
            @(negedge clk_pixel);
            h         = 11'(i % H_RES);
            v         = 11'(i / H_RES);
            pix_valid = 1'b1;
            pix_data  = frame_mem[i];
            hcount    = h;
            vcount    = v;
            exp_rgb_q.push_back(expected_rgb(frame_mem[i], h, v));
            exp_h_q.push_back(h);
            exp_v_q.push_back(v);
            exp_cyc_q.push_back(cycle_cnt + 2);
            if (in_window(luma_of(frame_mem[i]))) begin
                sum_x      += h;
                sum_y      += v;
                frame_hits += 1;
            end
        end
        @(negedge clk_pixel);
        pix_valid = 1'b0;
    endtask

    // Waits for the frame count to advance, then checks count and centroid
    task automatic check_frame_results();
        logic [31:0] data, cent;
        logic        err;
        model_frames = model_frames + 1;
        do begin
            apb_read(regmap_pkg::REG_FRAME, data, err);
            check_equal(err, 1'b0, "pslverr on frame count read");
        end while (data[15:0] != model_frames[15:0]);
        if (frame_hits != 0) begin
            model_cx   = 11'(sum_x / frame_hits);
            model_cy   = 11'(sum_y / frame_hits);
            model_have = 1'b1;
        end
        cent        = '0;
        cent[10:0]  = model_cx;
        cent[26:16] = model_cy;
        cent[31]    = model_have;
        read_expect(regmap_pkg::REG_COUNT, frame_hits, "masked pixel count");
        read_expect(regmap_pkg::REG_CENTROID, cent, "centroid register");
    endtask

    // Output monitor, sampled away from the rising edge
    always @(negedge clk_pixel) begin
        if (!recent_reset) begin
            if (exp_cyc_q.size() > 0 && exp_cyc_q[0] == cycle_cnt) begin
                check_equal(out_valid, 1'b1, "output valid");
                check_equal(out_rgb, exp_rgb_q.pop_front(), "output pixel colour");
                check_equal(out_hcount, exp_h_q.pop_front(), "output hcount");
                check_equal(out_vcount, exp_v_q.pop_front(), "output vcount");
                void'(exp_cyc_q.pop_front());
            end else begin
                check_equal(out_valid, 1'b0, "unexpected output pixel");
            end
        end
    end

    task automatic test_registers();
        logic [31:0] data;
        logic        err;
        read_expect(regmap_pkg::REG_THRESH_LO, 32'h80, "reset thresh_lo");
        read_expect(regmap_pkg::REG_THRESH_HI, 32'hFF, "reset thresh_hi");
        read_expect(regmap_pkg::REG_MODE, 32'(video_pkg::MODE_CAMERA), "reset mode");
        apb_read(regmap_pkg::REG_CENTROID, data, err);
        check_equal(err, 1'b0, "pslverr on centroid read");
        check_equal(data[31], 1'b0, "centroid valid bit after reset");
        read_expect(regmap_pkg::REG_COUNT, 32'h0, "reset count");
        read_expect(regmap_pkg::REG_FRAME, 32'h0, "reset frame count");
        write_reg(regmap_pkg::REG_THRESH_HI, 32'h5A);
        read_expect(regmap_pkg::REG_THRESH_HI, 32'h5A, "thresh_hi read-back");
        write_reg(regmap_pkg::REG_THRESH_HI, 32'hFF);
        apb_write(8'h18, 32'h12, err);
        check_equal(err, 1'b1, "pslverr on unmapped write");
        apb_read(8'h18, data, err);
        check_equal(err, 1'b1, "pslverr on unmapped read");
        apb_write(regmap_pkg::REG_COUNT, 32'h77, err);
        check_equal(err, 1'b1, "pslverr on read-only write");
        read_expect(regmap_pkg::REG_COUNT, 32'h0, "count after rejected write");
        read_expect(regmap_pkg::REG_THRESH_LO, 32'h80, "thresh_lo after bad accesses");
        read_expect(regmap_pkg::REG_THRESH_HI, 32'hFF, "thresh_hi after bad accesses");
        read_expect(regmap_pkg::REG_MODE, 32'(video_pkg::MODE_CAMERA), "mode after bad accesses");
    endtask

    task automatic run_frame(input logic [7:0] lo, input logic [7:0] hi,
                             input video_pkg::display_mode_e mode);
        configure(lo, hi, mode);
        send_frame();
        check_frame_results();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not complete within %0d ns", TIMEOUT_NS);
        $display("Something failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        recent_reset = 1'b1;
        pix_valid    = 1'b0;
        pix_data     = '0;
        hcount       = '0;
        vcount       = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        model_lo     = 8'h80;
        model_hi     = 8'hFF;
        model_mode   = video_pkg::MODE_CAMERA;
        model_cx     = '0;
        model_cy     = '0;
        model_have   = 1'b0;
        model_frames = 0;
        repeat (16) @(posedge clk_pixel);
        @(negedge clk_pixel);
        recent_reset = 1'b0;

        test_registers();
        run_frame(8'h80, 8'hFF, video_pkg::MODE_CAMERA);  // Also first centroid
        run_frame(8'h40, 8'hC0, video_pkg::MODE_LUMA);
        run_frame(8'h40, 8'hC0, video_pkg::MODE_MASK);
        run_frame(8'h80, 8'hFF, video_pkg::MODE_TRACK);
        run_frame(8'hFF, 8'hFF, video_pkg::MODE_CAMERA);  // Empty window

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
